/* verilog/gfx_pkg.sv */
`default_nettype none

package gfx_pkg;

    // 800x600 at 72 Hz, 50 MHz pixel clock
    localparam int H_VISIBLE = 800;
    localparam int H_FRONT   = 56;
    localparam int H_SYNC    = 120;
    localparam int H_BACK    = 64;
    localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;

    localparam int V_VISIBLE = 600;
    localparam int V_FRONT   = 37;
    localparam int V_SYNC    = 6;
    localparam int V_BACK    = 23;
    localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

    localparam int FRAME_PIXELS = H_VISIBLE * V_VISIBLE;

    // four 8-bit pixels per word
    localparam int FB_WORDS    = FRAME_PIXELS / 4;
    localparam int FB_AWIDTH   = 17;
    localparam int CONFIG_ADDR = FB_WORDS;

    typedef logic [31:0]          word_t;
    typedef logic [3:0]           byte_mask_t;
    typedef logic [FB_AWIDTH-1:0] fb_addr_t;
    typedef logic [17:0]          bus_addr_t;

    typedef struct packed {
        logic [2:0] red;
        logic [2:0] green;
        logic [1:0] blue;
    } color_t;

    typedef struct packed {
        logic       write;
        bus_addr_t  addr;
        word_t      wdata;
        byte_mask_t mask;
    } bus_req_t;

    typedef struct packed {
        word_t rdata;
    } bus_rsp_t;

    typedef struct packed {
        logic   hsync;
        logic   vsync;
        logic   de;
        color_t color;
    } vga_out_t;

    typedef enum logic {
        FETCH_RELOAD,
        FETCH_AHEAD
    } fetch_state_e;

endpackage

`default_nettype wire

/* verilog/frame_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module frame_buffer import gfx_pkg::*; (
    input  wire             vga_clk,
    input  wire fb_addr_t   a_addr_i,
    input  wire word_t      a_wdata_i,
    input  wire byte_mask_t a_mask_i,
    output word_t           a_rdata_o,
    input  wire fb_addr_t   b_addr_i,
    output word_t           b_rdata_o
);

    word_t mem [FB_WORDS];

    // port a, bus side, byte lanes written independently
    always_ff @(posedge vga_clk) begin
        for (int i = 0; i < 4; i++) begin
            if (a_mask_i[i]) begin
                mem[a_addr_i][8*i +: 8] <= a_wdata_i[8*i +: 8];
            end
        end
        a_rdata_o <= mem[a_addr_i];
    end

    // port b, display side, read only
    always_ff @(posedge vga_clk) begin
        b_rdata_o <= mem[b_addr_i];
    end

endmodule

`default_nettype wire

/* verilog/bus_slave.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_slave import gfx_pkg::*; (
    input  wire             vga_clk,
    input  wire             rst,
    input  wire             req_valid_i,
    output logic            req_ready_o,
    input  wire bus_req_t   req_i,
    output logic            rsp_valid_o,
    input  wire             rsp_ready_i,
    output bus_rsp_t        rsp_o,
    output fb_addr_t        fb_addr_o,
    output word_t           fb_wdata_o,
    output byte_mask_t      fb_mask_o,
    input  wire word_t      fb_rdata_i,
    output fb_addr_t        scroll_offset_o
);

    logic     accept;
    logic     is_fb;
    logic     is_cfg;
    logic     rd_fb;
    logic     rd_direct;
    logic     cfg_wr;
    logic     fb_wait_q;
    bus_rsp_t rsp_q;

    // one read in flight, held until the response is taken
    assign req_ready_o = !fb_wait_q && !rsp_valid_o;
    assign accept      = req_valid_i && req_ready_o;

    assign is_fb  = req_i.addr < bus_addr_t'(FB_WORDS);
    assign is_cfg = req_i.addr == bus_addr_t'(CONFIG_ADDR);

    assign rd_fb     = accept && !req_i.write && is_fb;
    assign rd_direct = accept && !req_i.write && !is_fb;
    assign cfg_wr    = accept && req_i.write && is_cfg;

    // port a follows the request, mask only on an accepted write
    assign fb_addr_o  = req_i.addr[FB_AWIDTH-1:0];
    assign fb_wdata_o = req_i.wdata;
    assign fb_mask_o  = (accept && req_i.write && is_fb) ? req_i.mask : '0;

    assign rsp_o = rsp_q;

    always_ff @(posedge vga_clk or posedge rst) begin
        if (rst) begin
            fb_wait_q       <= 1'b0;
            rsp_valid_o     <= 1'b0;
            scroll_offset_o <= '0;
        end else begin
            if (rsp_valid_o && rsp_ready_i) begin
                rsp_valid_o <= 1'b0;
            end
            // ram data lands one cycle after the read
            fb_wait_q <= rd_fb;
            if (fb_wait_q || rd_direct) begin
                rsp_valid_o <= 1'b1;
            end
            // out of range offsets are dropped
            if (cfg_wr && req_i.wdata < word_t'(FB_WORDS)) begin
                scroll_offset_o <= req_i.wdata[FB_AWIDTH-1:0];
            end
        end
    end

    always_ff @(posedge vga_clk) begin
        if (fb_wait_q) begin
            rsp_q.rdata <= fb_rdata_i;
        end else if (rd_direct) begin
            // unmapped reads give zero
            rsp_q.rdata <= is_cfg ? word_t'(scroll_offset_o) : '0;
        end
    end

endmodule

`default_nettype wire

/* verilog/vga_timing.sv */
`timescale 1ns/1ns
`default_nettype none

module vga_timing import gfx_pkg::*; (
    input  wire  vga_clk,
    input  wire  rst,
    output logic hsync_o,
    output logic vsync_o,
    output logic de_o,
    output logic frame_start_o
);

    logic [$clog2(H_TOTAL)-1:0] x_q;
    logic [$clog2(V_TOTAL)-1:0] y_q;
    logic                       line_end;
    logic                       h_active;
    logic                       v_active;

    assign line_end = x_q == H_TOTAL - 1;

    // beam position
    always_ff @(posedge vga_clk or posedge rst) begin
        if (rst) begin
            x_q <= '0;
            y_q <= '0;
        end else if (line_end) begin
            x_q <= '0;
            if (y_q == V_TOTAL - 1) begin
                y_q <= '0;
            end else begin
                y_q <= y_q + 1'b1;
            end
        end else begin
            x_q <= x_q + 1'b1;
        end
    end

    // positive sync pulses at the start of line and frame
    always_ff @(posedge vga_clk or posedge rst) begin
        if (rst) begin
            hsync_o <= 1'b1;
            vsync_o <= 1'b1;
        end else begin
            if (line_end) begin
                hsync_o <= 1'b1;
            end else if (x_q == H_SYNC - 1) begin
                hsync_o <= 1'b0;
            end
            if (line_end && y_q == V_TOTAL - 1) begin
                vsync_o <= 1'b1;
            end else if (line_end && y_q == V_SYNC - 1) begin
                vsync_o <= 1'b0;
            end
        end
    end

    assign h_active = x_q >= H_SYNC + H_BACK && x_q < H_SYNC + H_BACK + H_VISIBLE;
    assign v_active = y_q >= V_SYNC + V_BACK && y_q < V_SYNC + V_BACK + V_VISIBLE;

    assign de_o          = h_active && v_active;
    assign frame_start_o = x_q == '0 && y_q == '0;

endmodule

`default_nettype wire

/* verilog/pixel_fetch.sv */
`timescale 1ns/1ns
`default_nettype none

module pixel_fetch import gfx_pkg::*; (
    input  wire           vga_clk,
    input  wire           rst,
    input  wire           de_i,
    input  wire           frame_start_i,
    input  wire fb_addr_t scroll_offset_i,
    output fb_addr_t      rd_addr_o,
    input  wire word_t    rd_data_i,
    output color_t        color_o
);

    logic [FB_AWIDTH+1:0] count_q;
    fb_addr_t             offset_q;
    word_t                word_q;
    fetch_state_e         state;
    fb_addr_t             word_idx;
    logic [FB_AWIDTH:0]   addr_sum;
    logic [FB_AWIDTH:0]   addr_wrap;

    assign state    = de_i ? FETCH_AHEAD : FETCH_RELOAD;
    assign word_idx = count_q[FB_AWIDTH+1:2];

    // while active, look one word past the beam
    assign addr_sum  = word_idx + offset_q + fb_addr_t'(state == FETCH_AHEAD);
    assign addr_wrap = addr_sum - (FB_AWIDTH+1)'(FB_WORDS);
    assign rd_addr_o = (addr_sum >= FB_WORDS) ? addr_wrap[FB_AWIDTH-1:0]
                                              : addr_sum[FB_AWIDTH-1:0];

    always_ff @(posedge vga_clk or posedge rst) begin
        if (rst) begin
            count_q  <= '0;
            offset_q <= '0;
        end else begin
            // new offset only between frames
            if (frame_start_i) begin
                offset_q <= scroll_offset_i;
            end
            if (de_i) begin
                if (count_q == FRAME_PIXELS - 1) begin
                    count_q <= '0;
                end else begin
                    count_q <= count_q + 1'b1;
                end
            end
        end
    end

    // blanking keeps refreshing the word under the beam
    always_ff @(posedge vga_clk) begin
        if (state == FETCH_RELOAD || count_q[1:0] == 2'd3) begin
            word_q <= rd_data_i;
        end
    end

    // byte 0 is the leftmost pixel
    assign color_o = color_t'(word_q[{count_q[1:0], 3'b000} +: 8]);

endmodule

`default_nettype wire

/* verilog/graphics_controller.sv */
`timescale 1ns/1ns
`default_nettype none

module graphics_controller import gfx_pkg::*; (
    input  wire           vga_clk,
    input  wire           rst,
    input  wire           req_valid_i,
    output logic          req_ready_o,
    input  wire bus_req_t req_i,
    output logic          rsp_valid_o,
    input  wire           rsp_ready_i,
    output bus_rsp_t      rsp_o,
    output vga_out_t      vga_o
);

    fb_addr_t     fb_a_addr;
    word_t        fb_a_wdata;
    byte_mask_t   fb_a_mask;
    word_t        fb_a_rdata;
    fb_addr_t     fb_b_addr;
    word_t        fb_b_rdata;
    fb_addr_t     scroll_offset;
    logic         hsync;
    logic         vsync;
    logic         de;
    logic         frame_start;
    color_t       pixel_color;
    fetch_state_e fetch_state;

    bus_slave u_bus_slave (
        .vga_clk(vga_clk), .rst(rst),
        .req_valid_i(req_valid_i), .req_ready_o(req_ready_o), .req_i(req_i),
        .rsp_valid_o(rsp_valid_o), .rsp_ready_i(rsp_ready_i), .rsp_o(rsp_o),
        .fb_addr_o(fb_a_addr), .fb_wdata_o(fb_a_wdata), .fb_mask_o(fb_a_mask),
        .fb_rdata_i(fb_a_rdata), .scroll_offset_o(scroll_offset)
    );

    frame_buffer u_frame_buffer (
        .vga_clk(vga_clk),
        .a_addr_i(fb_a_addr), .a_wdata_i(fb_a_wdata), .a_mask_i(fb_a_mask),
        .a_rdata_o(fb_a_rdata), .b_addr_i(fb_b_addr), .b_rdata_o(fb_b_rdata)
    );

    vga_timing u_vga_timing (
        .vga_clk(vga_clk), .rst(rst),
        .hsync_o(hsync), .vsync_o(vsync), .de_o(de), .frame_start_o(frame_start)
    );

    pixel_fetch u_pixel_fetch (
        .vga_clk(vga_clk), .rst(rst),
        .de_i(de), .frame_start_i(frame_start), .scroll_offset_i(scroll_offset),
        .rd_addr_o(fb_b_addr), .rd_data_i(fb_b_rdata), .color_o(pixel_color)
    );

    // fetch mode seen from the top, black outside the active area
    assign fetch_state = de ? FETCH_AHEAD : FETCH_RELOAD;

    assign vga_o = '{hsync: hsync, vsync: vsync, de: de,
                     color: (fetch_state == FETCH_AHEAD) ? pixel_color : color_t'('0)};

endmodule

`default_nettype wire

/* tests/tb_graphics_controller.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_graphics_controller import gfx_pkg::*; ();

    localparam int SEED         = 32'h3718_e06f;
    localparam int S_START      = FB_WORDS - 200;
    localparam int REGION       = 600;
    localparam int MIXED_OPS    = 1200;
    localparam int CHECK_PIXELS = 2400;
    localparam int BUS_BUDGET   = 60000;
    localparam int CYCLE_LIMIT  = 3 * H_TOTAL * V_TOTAL + BUS_BUDGET;

    logic     vga_clk = 1'b0;
    logic     rst;
    logic     req_valid_i;
    logic     req_ready_o;
    bus_req_t req_i;
    logic     rsp_valid_o;
    logic     rsp_ready_i;
    bus_rsp_t rsp_o;
    vga_out_t vga_o;

    word_t    fb_model [FB_WORDS];
    fb_addr_t scroll_model;
    word_t    exp_q [$];
    logic     hold_rsp;
    int       cycles = 0;

    // sync checker state
    logic hs_prev, vs_prev, de_prev, h_seen, v_seen;
    int   h_cnt, v_cnt, de_run, de_lines, v_periods;

    graphics_controller u_dut (
        .vga_clk(vga_clk), .rst(rst),
        .req_valid_i(req_valid_i), .req_ready_o(req_ready_o), .req_i(req_i),
        .rsp_valid_o(rsp_valid_o), .rsp_ready_i(rsp_ready_i), .rsp_o(rsp_o),
        .vga_o(vga_o)
    );

    always #50 vga_clk = ~vga_clk;

    always @(posedge vga_clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            stop_run($sformatf("timeout, run did not finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Fail %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_color(input int n, input color_t got, input color_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Fail %0t: pixel %0d colour %h expected %h", $time, n, got, exp));
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            stop_run($sformatf("Fail %0t: %s is %0d expected %0d", $time, what, got, exp));
        end
    endtask

    function automatic bus_addr_t region_addr(input int i);
        return bus_addr_t'((S_START + i) % FB_WORDS);
    endfunction

    // raster pixel n against the model and the frame's scroll offset
    function automatic color_t expected_color(input int n);
        fb_addr_t idx;
        word_t    w;
        idx = fb_addr_t'((n / 4 + int'(scroll_model)) % FB_WORDS);
        w   = fb_model[idx];
        return color_t'(w[8 * (n % 4) +: 8]);
    endfunction

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic send_req(input logic wr, input bus_addr_t addr, input word_t data,
                            input byte_mask_t mask);
        fb_addr_t a;
        a                 = addr[FB_AWIDTH-1:0];
        req_i.write       = wr;
        req_i.addr        = addr;
        req_i.wdata       = data;
        req_i.mask        = mask;
        req_valid_i       = 1'b1;
        while (!req_ready_o) begin
            @(negedge vga_clk);
        end
        // the next rising edge takes it, writes get no response
        if (wr) begin
            if (addr < bus_addr_t'(FB_WORDS)) begin
                for (int i = 0; i < 4; i++) begin
                    if (mask[i]) begin
                        fb_model[a][8*i +: 8] = data[8*i +: 8];
                    end
                end
            end else if (addr == bus_addr_t'(CONFIG_ADDR) && data < word_t'(FB_WORDS)) begin
                scroll_model = data[FB_AWIDTH-1:0];
            end
        end else if (addr < bus_addr_t'(FB_WORDS)) begin
            exp_q.push_back(fb_model[a]);
        end else if (addr == bus_addr_t'(CONFIG_ADDR)) begin
            exp_q.push_back(word_t'(scroll_model));
        end else begin
            exp_q.push_back('0);
        end
        @(negedge vga_clk);
        req_valid_i = 1'b0;
    endtask

    task automatic serve_responses();
        forever begin
            @(negedge vga_clk);
            rsp_ready_i = hold_rsp ? 1'b0 : ($urandom_range(0, 2) != 0);
            if (rsp_valid_o && req_ready_o) begin
                stop_run("request channel was ready while a read response was pending");
            end else if (rsp_valid_o && rsp_ready_i) begin
                if (exp_q.size() == 0) begin
                    stop_run("read response arrived with no read outstanding");
                end else begin
                    check_word("read response", rsp_o.rdata, exp_q.pop_front());
                end
            end
        end
    endtask

    task automatic wait_frame_start();
        logic prev;
        prev = vga_o.vsync;
        @(negedge vga_clk);
        while (!(vga_o.vsync && !prev)) begin
            prev = vga_o.vsync;
            @(negedge vga_clk);
        end
    endtask

    // sync periods, pulse widths and active pixels per line
    always @(negedge vga_clk) begin
        if (rst) begin
            hs_prev = 1'b1;
            vs_prev = 1'b1;
            de_prev = 1'b0;
            h_seen = 1'b0;
            v_seen = 1'b0;
            h_cnt = 0;
            v_cnt = 0;
            de_run = 0;
            de_lines = 0;
            v_periods = 0;
        end else begin
            if (vga_o.hsync && !hs_prev) begin
                if (h_seen) check_count("hsync period", h_cnt, H_TOTAL);
                h_seen = 1'b1;
                h_cnt = 1;
            end else begin
                if (!vga_o.hsync && hs_prev && h_seen) check_count("hsync width", h_cnt, H_SYNC);
                h_cnt++;
            end
            if (vga_o.vsync && !vs_prev) begin
                if (v_seen) begin
                    check_count("vsync period", v_cnt, H_TOTAL * V_TOTAL);
                    check_count("active lines", de_lines, V_VISIBLE);
                    v_periods++;
                end
                v_seen = 1'b1;
                v_cnt = 1;
                de_lines = 0;
            end else begin
                if (!vga_o.vsync && vs_prev && v_seen) begin
                    check_count("vsync width", v_cnt, V_SYNC * H_TOTAL);
                end
                v_cnt++;
            end
            if (vga_o.de) begin
                de_run++;
            end else if (de_prev) begin
                check_count("de cycles per line", de_run, H_VISIBLE);
                de_run = 0;
                de_lines++;
            end
            hs_prev = vga_o.hsync;
            vs_prev = vga_o.vsync;
            de_prev = vga_o.de;
        end
    end

    initial begin
        int        i;
        int        n;
        bus_addr_t a;
        void'($urandom(SEED));
        rst = 1'b1;
        req_valid_i = 1'b0;
        req_i = '0;
        rsp_ready_i = 1'b0;
        hold_rsp = 1'b0;
        scroll_model = '0;
        repeat (16) @(negedge vga_clk);
        rst = 1'b0;
        fork
            serve_responses();
        join_none
        @(negedge vga_clk);

        // full words first so no byte is left undefined
        for (i = 0; i < REGION; i++) begin
            send_req(1'b1, region_addr(i), $urandom, 4'hf);
        end
        for (int k = 0; k < MIXED_OPS; k++) begin
            a = region_addr($urandom_range(0, REGION - 1));
            if ($urandom_range(0, 1) == 1) begin
                send_req(1'b1, a, $urandom, byte_mask_t'($urandom_range(0, 15)));
            end else begin
                send_req(1'b0, a, '0, '0);
            end
        end

        // write queued behind a held read response
        while (exp_q.size() != 0) begin
            @(negedge vga_clk);
        end
        a = region_addr(5);
        hold_rsp = 1'b1;
        send_req(1'b0, a, '0, '0);
        fork
            begin
                repeat (24) @(negedge vga_clk);
                hold_rsp = 1'b0;
            end
        join_none
        send_req(1'b1, a, $urandom, 4'hf);
        send_req(1'b0, a, '0, '0);

        // scroll register and unmapped space
        send_req(1'b1, bus_addr_t'(CONFIG_ADDR), word_t'(S_START), 4'hf);
        send_req(1'b0, bus_addr_t'(CONFIG_ADDR), '0, '0);
        send_req(1'b1, bus_addr_t'(CONFIG_ADDR), word_t'(FB_WORDS + $urandom_range(0, 999)), 4'hf);
        send_req(1'b1, bus_addr_t'(CONFIG_ADDR + 7), $urandom, 4'hf);
        send_req(1'b0, bus_addr_t'(CONFIG_ADDR), '0, '0);
        for (i = 0; i < 8; i++) begin
            send_req(1'b0, bus_addr_t'($urandom_range(CONFIG_ADDR + 1, 262143)), '0, '0);
        end
        while (exp_q.size() != 0) begin
            @(negedge vga_clk);
        end

        wait_frame_start();
        n = 0;
        while (n < CHECK_PIXELS) begin
            @(negedge vga_clk);
            if (vga_o.de) begin
                check_color(n, vga_o.color, expected_color(n));
                n++;
            end
        end

        // one more frame start closes a full vsync period
        wait_frame_start();
        repeat (4) @(negedge vga_clk);
        if (v_periods == 0) begin
            stop_run("no full vsync period was measured");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* graphics_controller.f */
verilog/gfx_pkg.sv
verilog/frame_buffer.sv
verilog/bus_slave.sv
verilog/vga_timing.sv
verilog/pixel_fetch.sv
verilog/graphics_controller.sv
tests/tb_graphics_controller.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_graphics_controller
FILELIST  ?= graphics_controller.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= Test passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
